// File: src/fc_pkg.sv
//////////////////////////////////////////////////
// Shared sizes and types of the FC compute core
// Imported by the feeder, the PEs, the drain, the
// chain interface and the top level
//////////////////////////////////////////////////

package fc_pkg;

  // One PE per output neuron
  localparam int NUM_LANES = 4;

  // Feature, weight and bias bytes
  localparam int DATA_W = 8;
  localparam int PROD_W = 2 * DATA_W;

  // Accumulator width
  localparam int ACC_W = 28;

  // Bias alignment and requantization window
  localparam int BIAS_SHIFT = 6;
  localparam int SAT_MSB    = 12;

  // Register stages in the PE multiplier
  localparam int MUL_STAGES = 3;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [PROD_W-1:0] prod_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // Lane 0 sits in the lowest byte
  typedef logic [NUM_LANES-1:0][DATA_W-1:0] lane_word_t;

  // Per-lane coefficients that meet a feature in a PE
  typedef struct packed {
    data_t weight;
    data_t bias;
  } lane_coef_t;

endpackage

// File: src/fc_chain_if.sv
//////////////////////////////////////////////////
// Systolic feature chain between neighbouring PEs
// The sender uses modport up, the receiver down
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface fc_chain_if;
  import fc_pkg::*;

  logic  valid;
  // Start and end of a vector
  logic  first;
  logic  last;
  data_t feat;

  modport up (
    output valid,
    output first,
    output last,
    output feat
  );

  modport down (
    input valid,
    input first,
    input last,
    input feat
  );

endinterface

// File: src/fc_feeder.sv
//////////////////////////////////////////////////
// Input stage of the FC core
// Registers host beats, starts the feature chain
// and skews weights and biases so that lane k
// sees its coefficients together with the feature
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fc_feeder (
  input  logic               clk,
  input  logic               rstn,
  input  logic               in_valid,
  input  logic               in_last,
  input  fc_pkg::data_t      in_feat,
  input  fc_pkg::lane_word_t in_weight,
  input  fc_pkg::lane_word_t in_bias,
  fc_chain_if.up             chain,
  output fc_pkg::lane_coef_t coef [fc_pkg::NUM_LANES]
);
  import fc_pkg::*;

  logic       beat_valid_q;
  logic       beat_first_q;
  logic       beat_last_q;
  data_t      beat_feat_q;
  lane_word_t beat_weight_q;
  lane_word_t beat_bias_q;

  // Set while the next beat opens a new vector
  logic       last_seen_q;

  //////////////////////////////////////////////////
  // Beat register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      beat_valid_q <= 1'b0;
      last_seen_q  <= 1'b1;
    end else begin
      beat_valid_q <= in_valid;
      if (in_valid) begin
        last_seen_q <= in_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    beat_first_q  <= last_seen_q;
    beat_last_q   <= in_last;
    beat_feat_q   <= in_feat;
    beat_weight_q <= in_weight;
    // Bias only counts on the closing beat
    beat_bias_q   <= in_last ? in_bias : '0;
  end

  //////////////////////////////////////////////////
  // Chain start
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      chain.valid <= 1'b0;
    end else begin
      chain.valid <= beat_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    chain.first <= beat_first_q;
    chain.last  <= beat_last_q;
    chain.feat  <= beat_feat_q;
  end

  // Lane k line is one register longer than lane k-1,
  // matching the one register per hop on the chain
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_skew
    lane_coef_t line_q [k+1];

    always_ff @(posedge clk) begin
      line_q[0].weight <= beat_weight_q[k];
      line_q[0].bias   <= beat_bias_q[k];
      for (int i = 1; i <= k; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end

    assign coef[k] = line_q[k];
  end

endmodule

// File: src/fc_pe.sv
//////////////////////////////////////////////////
// Processing element for one output neuron
// Sign-magnitude shift-add multiplier over three
// stages, then an accumulator that restarts on
// first and adds the shifted bias on last
// The feature is passed on with one register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fc_pe (
  input  logic               clk,
  input  logic               rstn,
  fc_chain_if.down           up,
  fc_chain_if.up             down,
  input  fc_pkg::lane_coef_t coef,
  output logic               res_valid,
  output fc_pkg::acc_t       res_sum
);
  import fc_pkg::*;

  // Control and bias beside the multiplier
  logic [MUL_STAGES-1:0] m_valid;
  logic [MUL_STAGES-1:0] m_first;
  logic [MUL_STAGES-1:0] m_last;
  data_t                 m_bias [MUL_STAGES];

  logic [DATA_W-1:0] a_mag;
  logic [DATA_W-1:0] b_mag;
  logic [DATA_W-1:0] pp_q [DATA_W];
  logic              sign_s1;
  logic [DATA_W+1:0] s2_q [DATA_W/2];
  logic              sign_s2;
  logic [PROD_W-1:0] mag_sum;
  prod_t             prod_q;

  acc_t prod_ext;
  acc_t bias_ext;
  acc_t acc_next;
  acc_t acc_q;

  //////////////////////////////////////////////////
  // Chain forwarding
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= up.valid;
    end
  end

  always_ff @(posedge clk) begin
    down.first <= up.first;
    down.last  <= up.last;
    down.feat  <= up.feat;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_valid <= '0;
    end else begin
      m_valid <= {m_valid[MUL_STAGES-2:0], up.valid};
    end
  end

  always_ff @(posedge clk) begin
    m_first   <= {m_first[MUL_STAGES-2:0], up.first};
    m_last    <= {m_last[MUL_STAGES-2:0], up.last};
    m_bias[0] <= coef.bias;
    for (int i = 1; i < MUL_STAGES; i++) begin
      m_bias[i] <= m_bias[i-1];
    end
  end

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////

  // -128 maps to 8'h80, which still fits unsigned
  always_comb begin
    a_mag = up.feat[DATA_W-1] ? DATA_W'(-up.feat) : DATA_W'(up.feat);
    b_mag = coef.weight[DATA_W-1] ? DATA_W'(-coef.weight) : DATA_W'(coef.weight);
  end

  // Stage 1 partial products, one per weight bit
  always_ff @(posedge clk) begin
    for (int i = 0; i < DATA_W; i++) begin
      pp_q[i] <= b_mag[i] ? a_mag : '0;
    end
    sign_s1 <= up.feat[DATA_W-1] ^ coef.weight[DATA_W-1];
  end

  // Stage 2 adds neighbouring rows
  always_ff @(posedge clk) begin
    for (int j = 0; j < DATA_W/2; j++) begin
      s2_q[j] <= {2'b00, pp_q[2*j]} + {1'b0, pp_q[2*j+1], 1'b0};
    end
    sign_s2 <= sign_s1;
  end

  always_comb begin
    mag_sum = '0;
    for (int j = 0; j < DATA_W/2; j++) begin
      mag_sum = mag_sum + (PROD_W'(s2_q[j]) << (2*j));
    end
  end

  // Stage 3 restores the sign
  always_ff @(posedge clk) begin
    prod_q <= sign_s2 ? prod_t'(-mag_sum) : prod_t'(mag_sum);
  end

  //////////////////////////////////////////////////
  // Accumulator and bias
  //////////////////////////////////////////////////

  always_comb begin
    prod_ext = acc_t'(prod_q);
    bias_ext = acc_t'(m_bias[MUL_STAGES-1]) <<< BIAS_SHIFT;
    acc_next = m_first[MUL_STAGES-1] ? prod_ext : acc_q + prod_ext;
  end

  always_ff @(posedge clk) begin
    if (m_valid[MUL_STAGES-1]) begin
      acc_q <= acc_next;
    end
    res_sum <= acc_next + bias_ext;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= m_valid[MUL_STAGES-1] & m_last[MUL_STAGES-1];
    end
  end

endmodule

// File: src/fc_drain.sv
//////////////////////////////////////////////////
// Output stage of the FC core
// Requantizes each lane sum, realigns the skewed
// lanes and emits one word per vector
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fc_drain (
  input  logic               clk,
  input  logic               rstn,
  input  logic               res_valid [fc_pkg::NUM_LANES],
  input  fc_pkg::acc_t       res_sum [fc_pkg::NUM_LANES],
  output logic               out_valid,
  output fc_pkg::lane_word_t out_data
);
  import fc_pkg::*;

  // ReLU, then clamp to 127, else take the fixed-point window
  function automatic data_t requant(input acc_t v);
    data_t r;
    if (v[ACC_W-1]) begin
      r = '0;
    end else if (|v[ACC_W-2:SAT_MSB+1]) begin
      r = 8'sd127;
    end else begin
      r = {1'b0, v[SAT_MSB:BIAS_SHIFT]};
    end
    return r;
  endfunction

  data_t held [NUM_LANES];

  // Lane k finishes NUM_LANES-1-k cycles before the last
  // lane, so its byte waits in a line of that length
  for (genvar k = 0; k < NUM_LANES - 1; k++) begin : g_hold
    localparam int DEPTH = NUM_LANES - 1 - k;
    data_t line_q [DEPTH];

    always_ff @(posedge clk) begin
      if (res_valid[k]) begin
        line_q[0] <= requant(res_sum[k]);
      end
      for (int i = 1; i < DEPTH; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end

    assign held[k] = line_q[DEPTH-1];
  end

  assign held[NUM_LANES-1] = requant(res_sum[NUM_LANES-1]);

  //////////////////////////////////////////////////
  // Word assembly
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (res_valid[NUM_LANES-1]) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        out_data[k] <= held[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= res_valid[NUM_LANES-1];
    end
  end

endmodule

// File: src/fc_core.sv
//////////////////////////////////////////////////
// Top level of the FC compute core
// One beat carries a feature byte, a weight byte
// per lane and, on the last beat, the lane biases
// A result word follows 9 cycles after a last beat
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fc_core (
  input  logic               clk,
  input  logic               rstn,
  input  logic               in_valid,
  input  logic               in_last,
  input  fc_pkg::data_t      in_feat,
  input  fc_pkg::lane_word_t in_weight,
  input  fc_pkg::lane_word_t in_bias,
  output logic               out_valid,
  output fc_pkg::lane_word_t out_data
);
  import fc_pkg::*;

  // Hop k feeds PE k, the final hop leaves the chain
  fc_chain_if chain [NUM_LANES+1] ();

  lane_coef_t coef [NUM_LANES];
  logic       res_valid [NUM_LANES];
  acc_t       res_sum [NUM_LANES];

  fc_feeder feeder_i (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .in_feat   (in_feat),
    .in_weight (in_weight),
    .in_bias   (in_bias),
    .chain     (chain[0]),
    .coef      (coef)
  );

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_pe
    fc_pe pe_i (
      .clk       (clk),
      .rstn      (rstn),
      .up        (chain[k]),
      .down      (chain[k+1]),
      .coef      (coef[k]),
      .res_valid (res_valid[k]),
      .res_sum   (res_sum[k])
    );
  end

  fc_drain drain_i (
    .clk       (clk),
    .rstn      (rstn),
    .res_valid (res_valid),
    .res_sum   (res_sum),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

// File: bench/tb_fc_core.sv
//////////////////////////////////////////////////
// Testbench for the FC compute core
// Streams random and corner-case vectors into the
// DUT on the falling edge and compares each result
// word and its latency against a reference model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_fc_core;
  import fc_pkg::*;

  typedef enum {MODE_RANDOM, MODE_SAT, MODE_NEG, MODE_ZERO_W, MODE_LANES} vec_mode_t;

  logic       clk;
  logic       rstn;
  logic       in_valid;
  logic       in_last;
  data_t      in_feat;
  lane_word_t in_weight;
  lane_word_t in_bias;
  logic       out_valid;
  lane_word_t out_data;

  integer seed = 53360;
  int     cycle = 0;

  // Vector under construction
  data_t      vec_feat [$];
  lane_word_t vec_weight [$];
  lane_word_t vec_bias;

  // Expected results in input order
  lane_word_t exp_word_q [$];
  int         exp_time_q [$];
  string      exp_name_q [$];

  fc_core dut_i (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .in_feat   (in_feat),
    .in_weight (in_weight),
    .in_bias   (in_bias),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = int'(($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
    return lo + r;
  endfunction

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "simulation stopped");
    end
  endtask

  // Dot product per lane plus 64 times the bias, then ReLU and clamp
  function automatic lane_word_t fc_ref(input data_t feat [$], input lane_word_t weight [$],
                                        input lane_word_t bias);
    lane_word_t r;
    int         sum;
    for (int k = 0; k < NUM_LANES; k++) begin
      sum = int'($signed(bias[k])) * (1 << BIAS_SHIFT);
      for (int i = 0; i < feat.size(); i++) begin
        sum = sum + int'(feat[i]) * int'($signed(weight[i][k]));
      end
      if (sum < 0) begin
        r[k] = 8'd0;
      end else if (sum >= (1 << (SAT_MSB + 1))) begin
        r[k] = 8'd127;
      end else begin
        r[k] = 8'(sum / (1 << BIAS_SHIFT));
      end
    end
    return r;
  endfunction

  task automatic make_vector(input vec_mode_t mode, input int len);
    lane_word_t w;
    data_t      f;
    vec_feat.delete();
    vec_weight.delete();
    case (mode)
      MODE_NEG:   vec_bias = {4{8'(rand_range(-128, -1))}};
      MODE_LANES: vec_bias = '0;
      default:    vec_bias = 32'($random(seed));
    endcase
    for (int i = 0; i < len; i++) begin
      f = data_t'(rand_range(-128, 127));
      for (int k = 0; k < NUM_LANES; k++) begin
        w[k] = 8'(rand_range(-128, 127));
      end
      case (mode)
        MODE_SAT: begin
          f = -8'sd128;
          w = {4{8'h80}};
        end
        MODE_NEG: begin
          f = data_t'(rand_range(1, 127));
          for (int k = 0; k < NUM_LANES; k++) begin
            w[k] = 8'(rand_range(-128, -1));
          end
        end
        MODE_ZERO_W: w = '0;
        // Distinct small weights land in distinct bytes
        MODE_LANES: begin
          f = 8'sd64;
          for (int k = 0; k < NUM_LANES; k++) begin
            w[k] = 8'((k + 1) * 10);
          end
        end
        default: ;
      endcase
      vec_feat.push_back(f);
      vec_weight.push_back(w);
    end
  endtask

  // Called right after a falling edge, returns right after one
  task automatic drive_vector(input string name, input int inner_gap, input int after_gap);
    int n;
    int gap;
    n = vec_feat.size();
    for (int i = 0; i < n; i++) begin
      in_valid  = 1'b1;
      in_last   = (i == n - 1);
      in_feat   = vec_feat[i];
      in_weight = vec_weight[i];
      // Junk bias on inner beats must be ignored
      in_bias   = (i == n - 1) ? vec_bias : 32'($random(seed));
      if (i == n - 1) begin
        exp_word_q.push_back(fc_ref(vec_feat, vec_weight, vec_bias));
        exp_time_q.push_back(cycle + 1);
        exp_name_q.push_back(name);
      end
      @(negedge clk);
      in_valid = 1'b0;
      in_last  = 1'b0;
      gap = (i == n - 1) ? rand_range(0, after_gap) : rand_range(0, inner_gap);
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_word_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > 200) begin
        abort("Timeout while waiting for pending result words");
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Result comparison
  //////////////////////////////////////////////////

  initial begin : compare_results
    string      name;
    lane_word_t word;
    int         t;
    forever begin
      @(negedge clk);
      if (out_valid === 1'b1) begin
        if (exp_word_q.size() == 0) begin
          abort("out_valid pulsed while no result was pending");
        end
        name = exp_name_q.pop_front();
        word = exp_word_q.pop_front();
        t    = exp_time_q.pop_front();
        check({name, " word"}, word, out_data);
        // Fixed pipeline depth from last beat to out_valid
        check({name, " latency"}, 32'd9, 32'(cycle - t));
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    rstn      = 1'b0;
    in_valid  = 1'b0;
    in_last   = 1'b0;
    in_feat   = '0;
    in_weight = '0;
    in_bias   = '0;
    repeat (4) begin
      @(negedge clk);
      check("reset", 32'd0, 32'(out_valid));
    end
    rstn = 1'b1;
    repeat (20) begin
      @(negedge clk);
      check("idle after reset", 32'd0, 32'(out_valid));
    end

    repeat (20) begin
      make_vector(MODE_RANDOM, rand_range(1, 16));
      drive_vector("single vector", 0, 0);
      wait_drain();
      repeat (rand_range(1, 5)) @(negedge clk);
    end

    repeat (20) begin
      make_vector(MODE_RANDOM, rand_range(1, 8));
      drive_vector("back to back", 0, 0);
    end
    repeat (20) begin
      make_vector(MODE_RANDOM, rand_range(1, 10));
      drive_vector("gapped", 3, 4);
    end
    wait_drain();

    repeat (3) begin
      make_vector(MODE_SAT, rand_range(16, 32));
      drive_vector("saturate", 0, 0);
    end
    repeat (4) begin
      make_vector(MODE_NEG, rand_range(1, 16));
      drive_vector("all negative", 0, 0);
    end
    repeat (4) begin
      make_vector(MODE_ZERO_W, rand_range(1, 8));
      drive_vector("zero weights", 0, 0);
    end
    repeat (4) begin
      make_vector(MODE_LANES, rand_range(1, 3));
      drive_vector("lane order", 0, 0);
    end
    wait_drain();

    repeat (30) begin
      make_vector(MODE_RANDOM, 1);
      drive_vector("length one", 0, 0);
    end

    // Every pending word must arrive, then the output stays quiet
    wait_drain();
    repeat (20) @(negedge clk);

    $display("Everything OK");
    $finish;
  end

endmodule

// File: src.f
src/fc_pkg.sv
src/fc_chain_if.sv
src/fc_feeder.sv
src/fc_pe.sv
src/fc_drain.sv
src/fc_core.sv
bench/tb_fc_core.sv

// File: run.sh
#!/bin/sh
# Build and run the FC core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_fc_core -o sim_fc_core

status=0
output=$(./obj_dir/sim_fc_core 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "^Everything OK$"; then
  exit 0
else
  echo "simulation exit status: $status"
  exit 1
fi
